// File: verilog/rv_pkg.sv
package rv_pkg;

    // Core data width and fetch start
    localparam int unsigned XLEN     = 64;
    localparam logic [31:0] RESET_PC = 32'd44;   // 0x2C, first main-program word
    localparam logic [31:0] NOP_WORD = 32'h0000_0013;   // ADDI x0,x0,0

    // Major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_OPIMM  = 7'b0010011,
        OP_OP     = 7'b0110011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_JAL    = 7'b1101111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    // Machine-mode CSR addresses that exist in csr_unit
    typedef enum logic [11:0] {
        CSR_MSTATUS = 12'h300,
        CSR_MIE     = 12'h304,
        CSR_MTVEC   = 12'h305,
        CSR_MEPC    = 12'h341,
        CSR_MCAUSE  = 12'h342,
        CSR_MIP     = 12'h344
    } csr_addr_e;

    // mstatus bit positions
    localparam int unsigned MSTATUS_MIE_BIT  = 3;
    localparam int unsigned MSTATUS_MPIE_BIT = 7;

    // External interrupt enable in mie, same position as MEIP in mip
    localparam int unsigned MIE_MEIE_BIT = 11;

    // Interrupt flag in bit 63, exception code 11
    localparam logic [63:0] MCAUSE_MEI = 64'h8000_0000_0000_000B;

    // MRET is one fixed word, no operand fields
    localparam logic [31:0] MRET_WORD = 32'h3020_0073;

    // Data memory map
    localparam logic [63:0] MMIO_OUT_ADDR = 64'h0000_0000_8000_0000;   // Output register
    localparam int unsigned RAM_WORDS     = 32;   // Doublewords
    localparam int unsigned RAM_AW        = $clog2(RAM_WORDS);
    localparam logic [63:0] RAM_BASE      = 64'h0000_0000_0000_1000;

endpackage

// File: verilog/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [4:0]               rs1_addr,
    input  logic [4:0]               rs2_addr,
    output logic [rv_pkg::XLEN-1:0]  rs1_data,
    output logic [rv_pkg::XLEN-1:0]  rs2_data,
    input  logic                     rd_we,
    input  logic [4:0]               rd_addr,
    input  logic [rv_pkg::XLEN-1:0]  rd_data
);

    // x0 has no storage
    logic [rv_pkg::XLEN-1:0] regs [1:31];

    // Single write port, takes effect at the edge
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && (rd_addr != 5'd0)) begin   // Drop writes to x0
            regs[rd_addr] <= rd_data;
        end
    end

    // Combinational reads, x0 hardwired to zero
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

    // No bypass
    // a write and a read of the same register in one cycle returns the old value,
    // which the core never needs since it writes back at the end of execute

endmodule

// File: verilog/csr_unit.sv
`timescale 1ns/10ps

module csr_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     irq,          // External interrupt level
    input  logic                     csr_we,
    input  logic [11:0]              csr_addr,
    input  logic [rv_pkg::XLEN-1:0]  csr_wdata,
    output logic [rv_pkg::XLEN-1:0]  csr_rdata,
    input  logic                     trap_take,    // Core enters the trap this cycle
    input  logic                     mret_take,    // Core executes MRET this cycle
    input  logic [31:0]              trap_pc,      // pc of the squashed instruction
    output logic                     irq_req,
    output logic [31:0]              mtvec_out,
    output logic [31:0]              mepc_out
);

    logic [rv_pkg::XLEN-1:0] mstatus;
    logic [rv_pkg::XLEN-1:0] mie;
    logic [rv_pkg::XLEN-1:0] mtvec;
    logic [rv_pkg::XLEN-1:0] mepc;
    logic [rv_pkg::XLEN-1:0] mcause;
    logic [rv_pkg::XLEN-1:0] mip;                  // Built from irq, not stored
    rv_pkg::csr_addr_e       csr_sel;

    assign csr_sel = rv_pkg::csr_addr_e'(csr_addr);

    // MEIP follows the pin, all other bits zero
    always_comb begin
        mip                       = '0;
        mip[rv_pkg::MIE_MEIE_BIT] = irq;
    end

    // The one interrupt decision in the system
    assign irq_req = irq & mstatus[rv_pkg::MSTATUS_MIE_BIT] & mie[rv_pkg::MIE_MEIE_BIT];

    // Read mux, unknown addresses give zero
    always_comb begin
        case (csr_sel)
            rv_pkg::CSR_MSTATUS: csr_rdata = mstatus;
            rv_pkg::CSR_MIE:     csr_rdata = mie;
            rv_pkg::CSR_MTVEC:   csr_rdata = mtvec;
            rv_pkg::CSR_MEPC:    csr_rdata = mepc;
            rv_pkg::CSR_MCAUSE:  csr_rdata = mcause;
            rv_pkg::CSR_MIP:     csr_rdata = mip;
            default:             csr_rdata = '0;
        endcase
    end

    // Trap entry and MRET own mstatus in their cycle, otherwise CSRRW writes
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus <= '0;
            mie     <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (trap_take) begin
            mepc                             <= {32'b0, trap_pc};
            mcause                           <= rv_pkg::MCAUSE_MEI;
            mstatus[rv_pkg::MSTATUS_MPIE_BIT] <= mstatus[rv_pkg::MSTATUS_MIE_BIT];
            mstatus[rv_pkg::MSTATUS_MIE_BIT]  <= 1'b0;   // Mask further interrupts
        end else if (mret_take) begin
            mstatus[rv_pkg::MSTATUS_MIE_BIT]  <= mstatus[rv_pkg::MSTATUS_MPIE_BIT];
            mstatus[rv_pkg::MSTATUS_MPIE_BIT] <= 1'b1;
        end else if (csr_we) begin
            case (csr_sel)
                rv_pkg::CSR_MSTATUS: mstatus <= csr_wdata;
                rv_pkg::CSR_MIE:     mie     <= csr_wdata;
                rv_pkg::CSR_MTVEC:   mtvec   <= csr_wdata;
                rv_pkg::CSR_MEPC:    mepc    <= csr_wdata;
                rv_pkg::CSR_MCAUSE:  mcause  <= csr_wdata;
                default: ;                   // mip read-only, rest ignored
            endcase
        end
    end

    // Redirect targets for the core, 32-bit pc space
    assign mtvec_out = mtvec[31:0];
    assign mepc_out  = mepc[31:0];

endmodule

// File: verilog/data_bus.sv
`timescale 1ns/10ps

module data_bus (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [rv_pkg::XLEN-1:0]  bus_address,
    input  logic [rv_pkg::XLEN-1:0]  bus_write_data,
    input  logic                     bus_write_enable,
    input  logic                     bus_read_enable,
    output logic [rv_pkg::XLEN-1:0]  bus_read_data,
    output logic                     out_strobe,      // High the cycle after an MMIO write
    output logic [rv_pkg::XLEN-1:0]  out_data
);

    logic [rv_pkg::XLEN-1:0] ram [0:rv_pkg::RAM_WORDS-1];
    logic [rv_pkg::XLEN-1:0] ram_offset;
    logic [rv_pkg::RAM_AW-1:0] ram_index;
    logic                    ram_hit;
    logic                    mmio_hit;

    // Address decode
    assign ram_offset = bus_address - rv_pkg::RAM_BASE;
    assign ram_index  = ram_offset[3 +: rv_pkg::RAM_AW];   // Doubleword index
    assign ram_hit    = (bus_address >= rv_pkg::RAM_BASE) &&
                        (ram_offset < 64'(rv_pkg::RAM_WORDS * 8));
    assign mmio_hit   = (bus_address == rv_pkg::MMIO_OUT_ADDR);

    // Same-cycle read, misses return zero
    always_comb begin
        bus_read_data = '0;
        if (bus_read_enable && ram_hit) begin
            bus_read_data = ram[ram_index];
        end else if (bus_read_enable && mmio_hit) begin
            bus_read_data = out_data;   // Output register reads back
        end
    end

    // RAM and output data capture at the edge
    always_ff @(posedge clk) begin
        if (bus_write_enable && ram_hit) ram[ram_index] <= bus_write_data;
        if (bus_write_enable && mmio_hit) out_data <= bus_write_data;
    end

    // One-cycle pulse per MMIO write
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            out_strobe <= 1'b0;
        end else begin
            out_strobe <= bus_write_enable && mmio_hit;
        end
    end

endmodule

// File: verilog/riscv64_core.sv
`timescale 1ns/10ps

module riscv64_core (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [31:0]              instruction,      // Word at pc, valid before the edge
    output logic [31:0]              pc,
    output logic                     heartbeat,
    // Register file
    output logic [4:0]               rs1_addr,
    output logic [4:0]               rs2_addr,
    input  logic [rv_pkg::XLEN-1:0]  rs1_data,
    input  logic [rv_pkg::XLEN-1:0]  rs2_data,
    output logic                     rd_we,
    output logic [4:0]               rd_addr,
    output logic [rv_pkg::XLEN-1:0]  rd_data,
    // CSR unit
    output logic                     csr_we,
    output logic [11:0]              csr_addr,
    output logic [rv_pkg::XLEN-1:0]  csr_wdata,
    input  logic [rv_pkg::XLEN-1:0]  csr_rdata,
    output logic                     trap_take,
    output logic                     mret_take,
    output logic [31:0]              trap_pc,
    input  logic                     irq_req,
    input  logic [31:0]              mtvec_out,
    input  logic [31:0]              mepc_out,
    // Data bus master
    output logic [rv_pkg::XLEN-1:0]  bus_address,
    output logic [rv_pkg::XLEN-1:0]  bus_write_data,
    output logic                     bus_write_enable,
    output logic                     bus_read_enable,
    input  logic [rv_pkg::XLEN-1:0]  bus_read_data
);

    logic [31:0]             ir;          // Fetch register
    logic [31:0]             ir_pc;       // Address ir came from
    logic                    bubble;      // ir holds a squashed fetch
    logic [31:0]             pc_next;
    logic                    redirect;
    logic                    live;        // ir really executes this cycle
    rv_pkg::opcode_e         opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [rv_pkg::XLEN-1:0] imm_u;
    logic [rv_pkg::XLEN-1:0] imm_i;
    logic [rv_pkg::XLEN-1:0] imm_s;
    logic [31:0]             imm_j;       // Only feeds the 32-bit pc
    logic                    is_lui;
    logic                    is_addi;
    logic                    is_add;
    logic                    is_ld;
    logic                    is_sd;
    logic                    is_jal;
    logic                    is_csrrw;
    logic                    is_mret;

    // Field split
    assign opcode   = rv_pkg::opcode_e'(ir[6:0]);
    assign funct3   = ir[14:12];
    assign funct7   = ir[31:25];
    assign rs1_addr = ir[19:15];
    assign rs2_addr = ir[24:20];
    assign rd_addr  = ir[11:7];

    // Immediates, all sign-extended
    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0};
    assign imm_i = {{52{ir[31]}}, ir[31:20]};
    assign imm_s = {{52{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

    // Interrupt wins over whatever sits in ir, bubbles never trap
    assign trap_take = irq_req && !bubble;
    assign trap_pc   = ir_pc;             // Squashed instruction resumes after MRET
    assign live      = !bubble && !trap_take;

    // Decode, anything unmatched is a no-op
    always_comb begin
        is_lui   = 1'b0;
        is_addi  = 1'b0;
        is_add   = 1'b0;
        is_ld    = 1'b0;
        is_sd    = 1'b0;
        is_jal   = 1'b0;
        is_csrrw = 1'b0;
        is_mret  = 1'b0;
        case (opcode)
            rv_pkg::OP_LUI:    is_lui  = live;
            rv_pkg::OP_OPIMM:  is_addi = live && (funct3 == 3'b000);
            rv_pkg::OP_OP:     is_add  = live && (funct3 == 3'b000) && (funct7 == 7'b0);
            rv_pkg::OP_LOAD:   is_ld   = live && (funct3 == 3'b011);   // Doubleword only
            rv_pkg::OP_STORE:  is_sd   = live && (funct3 == 3'b011);
            rv_pkg::OP_JAL:    is_jal  = live;
            rv_pkg::OP_SYSTEM: begin
                is_csrrw = live && (funct3 == 3'b001);
                is_mret  = live && (ir == rv_pkg::MRET_WORD);
            end
            default: ;
        endcase
    end

    // Write-back select
    assign rd_we = is_lui | is_addi | is_add | is_ld | is_jal | is_csrrw;
    always_comb begin
        rd_data = '0;
        if (is_lui)   rd_data = imm_u;
        if (is_addi)  rd_data = rs1_data + imm_i;
        if (is_add)   rd_data = rs1_data + rs2_data;
        if (is_ld)    rd_data = bus_read_data;      // Same-cycle bus read
        if (is_jal)   rd_data = {32'b0, ir_pc + 32'd4};   // Link address
        if (is_csrrw) rd_data = csr_rdata;           // Old CSR value
    end

    // CSR access and MRET pulse
    assign csr_we    = is_csrrw;
    assign csr_addr  = ir[31:20];
    assign csr_wdata = rs1_data;
    assign mret_take = is_mret;

    // Load/store, address from rs1 plus I or S offset
    assign bus_address      = rs1_data + (is_sd ? imm_s : imm_i);
    assign bus_write_data   = rs2_data;
    assign bus_write_enable = is_sd;
    assign bus_read_enable  = is_ld;

    // Next pc, trap first
    always_comb begin
        pc_next  = pc + 32'd4;
        redirect = 1'b1;
        if (trap_take)    pc_next = mtvec_out;
        else if (is_jal)  pc_next = ir_pc + imm_j;
        else if (is_mret) pc_next = mepc_out;
        else              redirect = 1'b0;
    end

    // Fetch and pc registers
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc        <= rv_pkg::RESET_PC;
            ir        <= rv_pkg::NOP_WORD;
            ir_pc     <= rv_pkg::RESET_PC;
            bubble    <= 1'b0;
            heartbeat <= 1'b0;
        end else begin
            pc        <= pc_next;
            ir        <= instruction;
            ir_pc     <= pc;
            bubble    <= redirect;          // Kill the fetch already in flight
            heartbeat <= ~heartbeat;        // Toggles every cycle
        end
    end

endmodule

// File: verilog/riscv64_soc.sv
`timescale 1ns/10ps

module riscv64_soc (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [31:0]              instruction,   // From external instruction memory
    output logic [31:0]              pc,
    input  logic                     irq,
    output logic                     heartbeat,
    output logic                     out_strobe,
    output logic [rv_pkg::XLEN-1:0]  out_data
);

    // Register file nets
    logic [4:0]              rs1_addr;
    logic [4:0]              rs2_addr;
    logic [rv_pkg::XLEN-1:0] rs1_data;
    logic [rv_pkg::XLEN-1:0] rs2_data;
    logic                    rd_we;
    logic [4:0]              rd_addr;
    logic [rv_pkg::XLEN-1:0] rd_data;
    // CSR nets
    logic                    csr_we;
    logic [11:0]             csr_addr;
    logic [rv_pkg::XLEN-1:0] csr_wdata;
    logic [rv_pkg::XLEN-1:0] csr_rdata;
    logic                    trap_take;
    logic                    mret_take;
    logic [31:0]             trap_pc;
    logic                    irq_req;
    logic [31:0]             mtvec_out;
    logic [31:0]             mepc_out;
    // Bus nets
    logic [rv_pkg::XLEN-1:0] bus_address;
    logic [rv_pkg::XLEN-1:0] bus_write_data;
    logic                    bus_write_enable;
    logic                    bus_read_enable;
    logic [rv_pkg::XLEN-1:0] bus_read_data;

    riscv64_core core0 (
        .clk, .reset, .instruction, .pc, .heartbeat,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data, .rd_we, .rd_addr, .rd_data,
        .csr_we, .csr_addr, .csr_wdata, .csr_rdata,
        .trap_take, .mret_take, .trap_pc, .irq_req, .mtvec_out, .mepc_out,
        .bus_address, .bus_write_data, .bus_write_enable, .bus_read_enable, .bus_read_data
    );

    reg_file rf0 (
        .clk, .reset, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .rd_we, .rd_addr, .rd_data
    );

    csr_unit csr0 (
        .clk, .reset, .irq, .csr_we, .csr_addr, .csr_wdata, .csr_rdata,
        .trap_take, .mret_take, .trap_pc, .irq_req, .mtvec_out, .mepc_out
    );

    data_bus bus0 (
        .clk, .reset, .bus_address, .bus_write_data, .bus_write_enable,
        .bus_read_enable, .bus_read_data, .out_strobe, .out_data
    );

endmodule

// File: dv/clock_gen.sv
`timescale 1ns/10ps

module clock_gen (
    output logic clk,
    output logic reset
);

    // 10 ns period, starts low
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Active-low reset over the first 8 rising edges
    initial begin
        reset = 1'b0;
        repeat (8) @(posedge clk);
        #1 reset = 1'b1;   // Released just after the edge
    end

endmodule

// File: dv/soc_tb.sv
`timescale 1ns/10ps

module soc_tb;

    logic        clk;
    logic        reset;
    logic [31:0] instruction;
    logic [31:0] pc;
    logic        irq;
    logic        heartbeat;
    logic        out_strobe;
    logic [63:0] out_data;

    logic [31:0] main_prog [$];   // Words from RESET_PC upward
    logic [31:0] isr_prog [$];    // Words from address 0 (mtvec)
    logic        row_irq [$];     // irq level per scenario row
    logic [63:0] row_exp [$];     // Expected out_data of the row's strobe
    logic        hb_exp;          // Expected heartbeat at the latest sample

    clock_gen clkgen0 (.clk, .reset);

    riscv64_soc dut0 (
        .clk, .reset, .instruction, .pc, .irq, .heartbeat, .out_strobe, .out_data
    );

    // Instruction encoders for the supported set
    function automatic logic [31:0] lui(logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, rv_pkg::OP_LUI};
    endfunction

    function automatic logic [31:0] addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, rv_pkg::OP_OPIMM};
    endfunction

    function automatic logic [31:0] add(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, rv_pkg::OP_OP};
    endfunction

    function automatic logic [31:0] ld(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b011, rd, rv_pkg::OP_LOAD};   // funct3 011 is doubleword
    endfunction

    function automatic logic [31:0] sd(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], rv_pkg::OP_STORE};
    endfunction

    function automatic logic [31:0] jal(logic [4:0] rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
    endfunction

    function automatic logic [31:0] csrrw(logic [4:0] rd, logic [11:0] csr, logic [4:0] rs1);
        return {csr, rs1, 3'b001, rd, rv_pkg::OP_SYSTEM};
    endfunction

    function automatic logic [31:0] mret();
        return {7'b0011000, 5'b00010, 5'b0, 3'b000, 5'b0, rv_pkg::OP_SYSTEM};
    endfunction

    // RV64 sign extension of a 32-bit result
    function automatic logic [63:0] sext32(logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    // Instruction memory lookup
    function automatic logic [31:0] fetch_word(logic [31:0] addr);
        int idx;
        if (addr >= rv_pkg::RESET_PC) begin
            idx = int'((addr - rv_pkg::RESET_PC) >> 2);
            if (idx < main_prog.size()) return main_prog[idx];
        end else begin
            idx = int'(addr >> 2);
            if (idx < isr_prog.size()) return isr_prog[idx];
        end
        return addi(5'd0, 5'd0, 12'd0);   // Unlisted words give a no-op
    endfunction

    task automatic load_program();
        main_prog.push_back(lui(5'd1, 20'h40000));            // x1 = 0x4000_0000
        main_prog.push_back(add(5'd1, 5'd1, 5'd1));           // 0x8000_0000 with no sign extension
        main_prog.push_back(lui(5'd3, 20'h89ABC));            // Negative upper half
        main_prog.push_back(addi(5'd3, 5'd3, 12'h123));
        main_prog.push_back(add(5'd4, 5'd3, 5'd3));
        main_prog.push_back(addi(5'd0, 5'd3, 12'h011));       // Dropped write to x0
        main_prog.push_back(add(5'd4, 5'd4, 5'd0));           // x0 must still read zero
        main_prog.push_back(sd(5'd4, 5'd1, 12'd0));           // Arithmetic result out
        main_prog.push_back(lui(5'd2, 20'h00001));            // x2 = RAM base
        main_prog.push_back(sd(5'd3, 5'd2, 12'd24));          // RAM doubleword 3
        main_prog.push_back(ld(5'd5, 5'd2, 12'd24));
        main_prog.push_back(sd(5'd5, 5'd1, 12'd0));           // Loaded copy out
        main_prog.push_back(jal(5'd6, 21'd8));                // Word 12 skips the next word
        main_prog.push_back(sd(5'd4, 5'd1, 12'd0));           // Poison store
        main_prog.push_back(addi(5'd8, 5'd0, 12'h7E1));
        main_prog.push_back(sd(5'd8, 5'd1, 12'd0));           // Post-jump value out
        main_prog.push_back(addi(5'd9, 5'd0, 12'h400));
        main_prog.push_back(add(5'd9, 5'd9, 5'd9));           // MEIE mask 0x800
        main_prog.push_back(csrrw(5'd0, rv_pkg::CSR_MTVEC, 5'd0));
        main_prog.push_back(csrrw(5'd0, rv_pkg::CSR_MIE, 5'd9));
        main_prog.push_back(addi(5'd9, 5'd0, 12'd8));         // mstatus.MIE
        main_prog.push_back(csrrw(5'd0, rv_pkg::CSR_MSTATUS, 5'd9));
        main_prog.push_back(sd(5'd6, 5'd1, 12'd0));           // Link address out
        main_prog.push_back(jal(5'd0, 21'd0));                // Spin until the interrupt
        main_prog.push_back(addi(5'd14, 5'd0, 12'hFFD));      // Resume point after MRET
        main_prog.push_back(sd(5'd14, 5'd1, 12'd0));
        main_prog.push_back(jal(5'd0, 21'd0));
        // ISR at mtvec = 0
        isr_prog.push_back(addi(5'd10, 5'd0, 12'h3C5));       // Marker
        isr_prog.push_back(sd(5'd10, 5'd1, 12'd0));
        isr_prog.push_back(csrrw(5'd11, rv_pkg::CSR_MCAUSE, 5'd0));
        isr_prog.push_back(sd(5'd11, 5'd1, 12'd0));
        isr_prog.push_back(csrrw(5'd12, rv_pkg::CSR_MSTATUS, 5'd0));
        isr_prog.push_back(csrrw(5'd0, rv_pkg::CSR_MSTATUS, 5'd12));   // Put it back
        isr_prog.push_back(sd(5'd12, 5'd1, 12'd0));
        isr_prog.push_back(csrrw(5'd13, rv_pkg::CSR_MEPC, 5'd0));
        isr_prog.push_back(addi(5'd13, 5'd13, 12'd4));        // Step past the spin loop
        isr_prog.push_back(csrrw(5'd0, rv_pkg::CSR_MEPC, 5'd13));
        isr_prog.push_back(mret());
    endtask

    task automatic add_row(input logic irq_level, input logic [63:0] exp);
        row_irq.push_back(irq_level);
        row_exp.push_back(exp);
    endtask

    task automatic load_scenarios();
        logic [63:0] x3_val;
        x3_val = sext32(32'h89AB_C000) + 64'h123;              // LUI then ADDI
        add_row(1'b0, x3_val + x3_val);
        add_row(1'b0, x3_val);                                 // RAM round trip
        add_row(1'b0, 64'h7E1);
        add_row(1'b0, 64'(rv_pkg::RESET_PC) + 64'd12 * 4 + 64'd4);   // Link of word 12
        add_row(1'b1, 64'h3C5);
        add_row(1'b1, {1'b1, 63'd11});                         // Interrupt flag with code 11
        add_row(1'b1, 64'd1 << rv_pkg::MSTATUS_MPIE_BIT);      // MPIE set and MIE clear
        add_row(1'b0, {{52{1'b1}}, 12'hFFD});                  // ADDI -3
    endtask

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] got);
        if (got !== exp) begin
            $display("ERR %s exp=%h got=%h", name, exp, got);
            $display("=== FAIL ===");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Sample at the falling edge until out_strobe shows
    task automatic wait_output();
        do begin
            @(negedge clk);
            hb_exp = ~hb_exp;   // Heartbeat flips every cycle
            check("heartbeat", {63'd0, hb_exp}, {63'd0, heartbeat});
        end while (!out_strobe);
    endtask

    // Instruction for the current pc shortly after each rising edge
    always @(posedge clk) begin
        #1 instruction = fetch_word(pc);
    end

    initial begin
        irq         = 1'b0;
        instruction = addi(5'd0, 5'd0, 12'd0);
        load_program();
        load_scenarios();
        // Reset state through the first sample after release
        do begin
            @(negedge clk);
            check("pc", 64'(rv_pkg::RESET_PC), 64'(pc));
            check("out_strobe", 64'd0, {63'd0, out_strobe});
            check("heartbeat", 64'd0, {63'd0, heartbeat});
        end while (!reset);
        hb_exp = 1'b0;
        @(posedge clk);
        #1;
        for (int r = 0; r < row_exp.size(); r++) begin
            irq = row_irq[r];
            wait_output();
            check("out_data", row_exp[r], out_data);
            @(posedge clk);
            #1 irq = 1'b0;   // Dropped once the row's output is seen
        end
        $display("=== PASS ===");
        $finish;
    end

    // Watchdog allows 200 cycles per scenario row
    initial begin
        @(posedge reset);
        repeat (200 * row_exp.size()) @(posedge clk);
        $display("Timeout: no output strobe within %0d cycles", 200 * row_exp.size());
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: sim.f
verilog/rv_pkg.sv
verilog/reg_file.sv
verilog/csr_unit.sv
verilog/data_bus.sv
verilog/riscv64_core.sv
verilog/riscv64_soc.sv
dv/clock_gen.sv
dv/soc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator from sim.f and run; exit status follows the testbench
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module soc_tb -f sim.f -o soc_tb_sim &&
./obj_dir/soc_tb_sim ||
{ echo "simulation failed"; exit 1; }
